//--- Makefile
SIM       := verilator
TOP       := branch_unit_tb
FILELIST  := verilog.f
FLAGS     := --binary --timing --assert
SIM_ARGS  := +verilator+error+limit+1000
BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/branch_macros.svh
/*
 * Widths and counts shared by the branch unit RTL and its testbench.
 * Include in any file that needs one of these values.
 */
`ifndef BRANCH_MACROS_SVH
`define BRANCH_MACROS_SVH

// Pipeline datapath
`define WORD_WIDTH      36      // Thread result word
`define PC_WIDTH        10
`define THREAD_COUNT    8       // Barrel slots
`define THREAD_WIDTH    3

// Branch condition flags
`define COND_WIDTH      8
`define COND_SEL_WIDTH  3       // Index into the flag set

// Entry register bus
`define AXI_ADDR_WIDTH  7       // 8 threads of 4 words
`define AXI_DATA_WIDTH  32

`endif

//--- src/branch_detector.sv
/*
 * Two stage branch decision. Stage one matches the PC against the thread's
 * entry, stage two applies the selected flag and picks the next PC.
 */
`timescale 1ns/1ps
`include "branch_macros.svh"

module branch_detector (
    input  logic                                       clock,
    input  logic                                       arst_n,
    input  logic                                       in_valid,
    input  branch_pkg::thread_t                        in_thread,
    input  branch_pkg::pc_t                            in_pc,
    input  branch_pkg::cond_t                          flags,
    input  branch_pkg::pc_t       [`THREAD_COUNT-1:0]  entry_origin,
    input  branch_pkg::pc_t       [`THREAD_COUNT-1:0]  entry_dest,
    input  branch_pkg::cond_sel_t [`THREAD_COUNT-1:0]  entry_cond_sel,
    input  logic                  [`THREAD_COUNT-1:0]  entry_enable,
    output logic                                       out_valid,
    output branch_pkg::thread_t                        out_thread,
    output branch_pkg::pc_t                            next_pc,
    output logic                                       taken
);
    import branch_pkg::*;

    logic      entry_hit;
    logic      s1_valid;
    logic      s1_match;
    thread_t   s1_thread;
    pc_t       s1_pc;
    pc_t       s1_dest;
    cond_sel_t s1_cond_sel;
    logic      s2_taken;

    // Enabled entry whose origin equals the entering PC
    assign entry_hit = entry_enable[in_thread] && (entry_origin[in_thread] == in_pc);

    // Flags line up with stage one
    assign s2_taken = s1_match && flags[s1_cond_sel];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            s1_match  <= 1'b0;
            out_valid <= 1'b0;
            taken     <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            s1_match  <= entry_hit;
            out_valid <= s1_valid;
            taken     <= s2_taken;
        end
    end

    // Payload follows the valid bits down the pipe
    always_ff @(posedge clock) begin
        s1_thread   <= in_thread;
        s1_pc       <= in_pc;
        s1_dest     <= entry_dest[in_thread];
        s1_cond_sel <= entry_cond_sel[in_thread];

        out_thread  <= s1_thread;
        if (s2_taken) begin
            next_pc <= s1_dest;
        end else begin
            next_pc <= pc_t'(s1_pc + 1'b1);  // Wraps at top of PC range
        end
    end

endmodule

//--- src/branch_entry_regs.sv
/*
 * AXI4-Lite slave holding one branch entry per thread.
 * Address is thread * 16 + word * 4; words are origin, destination, control.
 */
`timescale 1ns/1ps
`include "branch_macros.svh"

module branch_entry_regs (
    input  logic                                       clock,
    input  logic                                       arst_n,
    input  branch_pkg::axi_addr_t                      awaddr,
    input  logic                                       awvalid,
    output logic                                       awready,
    input  branch_pkg::axi_data_t                      wdata,
    input  logic [`AXI_DATA_WIDTH/8-1:0]               wstrb,
    input  logic                                       wvalid,
    output logic                                       wready,
    output logic [1:0]                                 bresp,
    output logic                                       bvalid,
    input  logic                                       bready,
    input  branch_pkg::axi_addr_t                      araddr,
    input  logic                                       arvalid,
    output logic                                       arready,
    output branch_pkg::axi_data_t                      rdata,
    output logic [1:0]                                 rresp,
    output logic                                       rvalid,
    input  logic                                       rready,
    output branch_pkg::pc_t       [`THREAD_COUNT-1:0]  entry_origin,
    output branch_pkg::pc_t       [`THREAD_COUNT-1:0]  entry_dest,
    output branch_pkg::cond_sel_t [`THREAD_COUNT-1:0]  entry_cond_sel,
    output logic                  [`THREAD_COUNT-1:0]  entry_enable
);
    import branch_pkg::*;

    axi_wr_state_t wr_state;
    axi_rd_state_t rd_state;
    thread_t       wr_thread;
    thread_t       rd_thread;
    logic [1:0]    wr_word;
    logic [1:0]    rd_word;
    logic          wr_accept;
    logic          rd_accept;
    axi_data_t     wr_merged;

    // Packed register view of one entry word, unused bits zero
    function automatic axi_data_t reg_view(thread_t thread, logic [1:0] word);
        axi_data_t view;
        view = '0;
        case (word)
            2'd0: view[`PC_WIDTH-1:0] = entry_origin[thread];
            2'd1: view[`PC_WIDTH-1:0] = entry_dest[thread];
            2'd2: begin
                view[`COND_SEL_WIDTH-1:0] = entry_cond_sel[thread];
                view[8]                   = entry_enable[thread];   // Enable bit
            end
            default: view = '0;     // Word 3 reads as zero
        endcase
        return view;
    endfunction

    // Byte lanes without a strobe keep their old contents
    function automatic axi_data_t apply_strb(axi_data_t old, axi_data_t data,
                                             logic [`AXI_DATA_WIDTH/8-1:0] strb);
        axi_data_t merged;
        merged = old;
        for (int i = 0; i < `AXI_DATA_WIDTH/8; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = data[8*i +: 8];
            end
        end
        return merged;
    endfunction

    assign wr_thread = awaddr[`AXI_ADDR_WIDTH-1:4];
    assign wr_word   = awaddr[3:2];
    assign rd_thread = araddr[`AXI_ADDR_WIDTH-1:4];
    assign rd_word   = araddr[3:2];

    assign wr_accept = awready && wready && awvalid && wvalid;
    assign rd_accept = arready && arvalid;
    assign wr_merged = apply_strb(reg_view(wr_thread, wr_word), wdata, wstrb);

    assign bresp = 2'b00;   // Always OKAY
    assign rresp = 2'b00;

    // Write channel and entry storage
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_state       <= wr_idle;
            awready        <= 1'b0;
            wready         <= 1'b0;
            bvalid         <= 1'b0;
            entry_origin   <= '0;
            entry_dest     <= '0;
            entry_cond_sel <= '0;
            entry_enable   <= '0;
        end else begin
            case (wr_state)
                wr_idle: begin
                    if (wr_accept) begin
                        awready  <= 1'b0;
                        wready   <= 1'b0;
                        bvalid   <= 1'b1;
                        wr_state <= wr_response;
                        case (wr_word)
                            2'd0: entry_origin[wr_thread] <= wr_merged[`PC_WIDTH-1:0];
                            2'd1: entry_dest[wr_thread]   <= wr_merged[`PC_WIDTH-1:0];
                            2'd2: begin
                                entry_cond_sel[wr_thread] <= wr_merged[`COND_SEL_WIDTH-1:0];
                                entry_enable[wr_thread]   <= wr_merged[8];
                            end
                            default: ;  // Word 3 ignores writes
                        endcase
                    end else if (awvalid && wvalid) begin
                        awready <= 1'b1;    // Both channels present, accept next edge
                        wready  <= 1'b1;
                    end
                end
                wr_response: begin
                    if (bready) begin
                        bvalid   <= 1'b0;
                        wr_state <= wr_idle;
                    end
                end
                default: wr_state <= wr_idle;
            endcase
        end
    end

    // Read channel control
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_state <= rd_idle;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            case (rd_state)
                rd_idle: begin
                    if (rd_accept) begin
                        arready  <= 1'b0;
                        rvalid   <= 1'b1;
                        rd_state <= rd_data;
                    end else if (arvalid) begin
                        arready <= 1'b1;
                    end
                end
                rd_data: begin
                    if (rready) begin
                        rvalid   <= 1'b0;
                        rd_state <= rd_idle;
                    end
                end
                default: rd_state <= rd_idle;
            endcase
        end
    end

    // Read data is captured once and held while rvalid waits
    always_ff @(posedge clock) begin
        if (rd_accept) begin
            rdata <= reg_view(rd_thread, rd_word);
        end
    end

endmodule

//--- src/branch_flags.sv
/*
 * Condition flags for the branch detector, registered one cycle after the
 * previous result so they line up with the detector's first stage.
 */
`timescale 1ns/1ps
`include "branch_macros.svh"

module branch_flags (
    input  logic              clock,
    input  logic              arst_n,
    input  branch_pkg::word_t r_prev,
    output branch_pkg::cond_t flags
);
    import branch_pkg::*;

    logic  is_zero;
    logic  is_negative;
    logic  is_even;
    cond_t flags_next;

    assign is_zero     = (r_prev == '0);
    assign is_negative = r_prev[`WORD_WIDTH-1];  // Sign bit
    assign is_even     = ~r_prev[0];

    // Fixed flag positions, one per condition select value
    always_comb begin
        flags_next    = '0;             // Bits 5 and 6 reserved
        flags_next[0] = 1'b1;           // Always
        flags_next[1] = is_zero;
        flags_next[2] = ~is_zero;
        flags_next[3] = ~is_negative;   // Positive, top bit clear
        flags_next[4] = is_negative;
        flags_next[7] = is_even;        // Hailstone style custom test
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else begin
            flags <= flags_next;
        end
    end

endmodule

//--- src/branch_pkg.sv
/*
 * Types for the branch unit datapath and its register bus.
 * Modules name these through branch_pkg, by scope in ports and by import in bodies.
 */
`include "branch_macros.svh"

package branch_pkg;

    typedef logic [`WORD_WIDTH-1:0]     word_t;      // Previous thread result
    typedef logic [`PC_WIDTH-1:0]       pc_t;
    typedef logic [`THREAD_WIDTH-1:0]   thread_t;
    typedef logic [`COND_WIDTH-1:0]     cond_t;      // Full flag set
    typedef logic [`COND_SEL_WIDTH-1:0] cond_sel_t;

    typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [`AXI_DATA_WIDTH-1:0] axi_data_t;

    // Write channel, response held until bready
    typedef enum logic {
        wr_idle,
        wr_response
    } axi_wr_state_t;

    // Read channel, data held until rready
    typedef enum logic {
        rd_idle,
        rd_data
    } axi_rd_state_t;

endpackage

//--- src/branch_unit.sv
/*
 * Branch unit top for the eight thread barrel pipeline.
 * Connects the flag register, the AXI4-Lite entry registers and the detector.
 */
`timescale 1ns/1ps
`include "branch_macros.svh"

module branch_unit (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  branch_pkg::thread_t           in_thread,
    input  branch_pkg::pc_t               in_pc,
    input  branch_pkg::word_t             r_prev,
    output logic                          out_valid,
    output branch_pkg::thread_t           out_thread,
    output branch_pkg::pc_t               next_pc,
    output logic                          taken,
    input  branch_pkg::axi_addr_t         awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  branch_pkg::axi_data_t         wdata,
    input  logic [`AXI_DATA_WIDTH/8-1:0]  wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  branch_pkg::axi_addr_t         araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output branch_pkg::axi_data_t         rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready
);
    import branch_pkg::*;

    cond_t                         flags;
    pc_t       [`THREAD_COUNT-1:0] entry_origin;
    pc_t       [`THREAD_COUNT-1:0] entry_dest;
    cond_sel_t [`THREAD_COUNT-1:0] entry_cond_sel;
    logic      [`THREAD_COUNT-1:0] entry_enable;

    branch_flags branch_flags_inst (
        .clock  (clock),
        .arst_n (arst_n),
        .r_prev (r_prev),
        .flags  (flags)
    );

    branch_entry_regs branch_entry_regs_inst (
        .clock          (clock),
        .arst_n         (arst_n),
        .awaddr         (awaddr),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .wvalid         (wvalid),
        .wready         (wready),
        .bresp          (bresp),
        .bvalid         (bvalid),
        .bready         (bready),
        .araddr         (araddr),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rvalid         (rvalid),
        .rready         (rready),
        .entry_origin   (entry_origin),
        .entry_dest     (entry_dest),
        .entry_cond_sel (entry_cond_sel),
        .entry_enable   (entry_enable)
    );

    branch_detector branch_detector_inst (
        .clock          (clock),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_thread      (in_thread),
        .in_pc          (in_pc),
        .flags          (flags),
        .entry_origin   (entry_origin),
        .entry_dest     (entry_dest),
        .entry_cond_sel (entry_cond_sel),
        .entry_enable   (entry_enable),
        .out_valid      (out_valid),
        .out_thread     (out_thread),
        .next_pc        (next_pc),
        .taken          (taken)
    );

endmodule

//--- tb/branch_unit_props.sv
/*
 * Concurrent checks on pipeline latency and AXI4-Lite handshakes.
 * Bound into branch_unit from the testbench.
 */
`timescale 1ns/1ps

module branch_unit_props (
    input logic                  clock,
    input logic                  arst_n,
    input logic                  in_valid,
    input branch_pkg::thread_t   in_thread,
    input logic                  out_valid,
    input branch_pkg::thread_t   out_thread,
    input logic                  awvalid,
    input logic                  awready,
    input logic                  wvalid,
    input logic                  wready,
    input logic                  bvalid,
    input logic                  bready,
    input logic                  arvalid,
    input logic                  arready,
    input logic                  rvalid,
    input logic                  rready,
    input branch_pkg::axi_data_t rdata
);
    int failures = 0;   // Read by the testbench at the end of the run

    // Two stage latency, items kept in order
    valid_latency: assert property (@(posedge clock) disable iff (!arst_n)
        out_valid == $past(in_valid, 2))
        else begin
            $error("out_valid does not follow in_valid by two cycles");
            failures++;
        end

    thread_latency: assert property (@(posedge clock) disable iff (!arst_n)
        out_valid |-> out_thread == $past(in_thread, 2))
        else begin
            $error("out_thread does not match the thread sent two cycles earlier");
            failures++;
        end

    // Master side valids wait for their ready
    awvalid_hold: assert property (@(posedge clock) disable iff (!arst_n)
        (awvalid && !awready) |=> awvalid)
        else begin
            $error("awvalid dropped before awready");
            failures++;
        end

    wvalid_hold: assert property (@(posedge clock) disable iff (!arst_n)
        (wvalid && !wready) |=> wvalid)
        else begin
            $error("wvalid dropped before wready");
            failures++;
        end

    arvalid_hold: assert property (@(posedge clock) disable iff (!arst_n)
        (arvalid && !arready) |=> arvalid)
        else begin
            $error("arvalid dropped before arready");
            failures++;
        end

    bvalid_hold: assert property (@(posedge clock) disable iff (!arst_n)
        (bvalid && !bready) |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            failures++;
        end

    rvalid_hold: assert property (@(posedge clock) disable iff (!arst_n)
        (rvalid && !rready) |=> (rvalid && $stable(rdata)))
        else begin
            $error("rvalid dropped or rdata changed before rready");
            failures++;
        end

    // Responses only after an accepted request
    bvalid_cause: assert property (@(posedge clock) disable iff (!arst_n)
        $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready))
        else begin
            $error("bvalid rose without a write accept");
            failures++;
        end

    rvalid_cause: assert property (@(posedge clock) disable iff (!arst_n)
        $rose(rvalid) |-> $past(arvalid && arready))
        else begin
            $error("rvalid rose without a read accept");
            failures++;
        end

endmodule

//--- tb/branch_unit_tb.sv
/*
 * Testbench for the branch unit. Programs entries over AXI4-Lite, streams
 * pipeline items and checks every output against a shadow entry model.
 */
`timescale 1ns/1ps
`include "branch_macros.svh"

module branch_unit_tb;
    import branch_pkg::*;

    localparam int TIMEOUT = 40;    // Cycles allowed per handshake wait

    typedef struct packed {
        logic    valid;
        thread_t thread;
        logic    taken;
        pc_t     next_pc;
    } item_t;

    logic                         clock;
    logic                         arst_n;
    logic                         in_valid;
    thread_t                      in_thread;
    pc_t                          in_pc;
    word_t                        r_prev;
    logic                         out_valid;
    thread_t                      out_thread;
    pc_t                          next_pc;
    logic                         taken;
    axi_addr_t                    awaddr;
    axi_addr_t                    araddr;
    axi_data_t                    wdata;
    axi_data_t                    rdata;
    logic [`AXI_DATA_WIDTH/8-1:0] wstrb;
    logic [1:0]                   bresp;
    logic [1:0]                   rresp;
    logic                         awvalid;
    logic                         awready;
    logic                         wvalid;
    logic                         wready;
    logic                         bvalid;
    logic                         bready;
    logic                         arvalid;
    logic                         arready;
    logic                         rvalid;
    logic                         rready;

    // Shadow of the entries held in the DUT
    pc_t       shadow_origin [`THREAD_COUNT] = '{default: '0};
    pc_t       shadow_dest   [`THREAD_COUNT] = '{default: '0};
    cond_sel_t shadow_sel    [`THREAD_COUNT] = '{default: '0};
    logic      shadow_enable [`THREAD_COUNT] = '{default: '0};

    item_t  sent [$];       // Items still inside the DUT pipeline
    item_t  expected_out;
    int     checks = 0;
    int     errors = 0;
    integer seed;
    word_t  results [4] = '{36'h0, 36'h0_1234_5677, 36'h8_0000_0010, 36'h7_FFFF_FFFE};

    branch_unit branch_unit_inst (.*);

    bind branch_unit branch_unit_props branch_unit_props_inst (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic axi_data_t expected_word(thread_t t, logic [1:0] word);
        case (word)
            2'd0: return {22'd0, shadow_origin[t]};
            2'd1: return {22'd0, shadow_dest[t]};
            2'd2: return {23'd0, shadow_enable[t], 5'd0, shadow_sel[t]};
            default: return '0;     // Word 3 is empty
        endcase
    endfunction

    // Flag rule, entry match and next PC for one item
    function automatic item_t predict(thread_t t, pc_t pc, word_t r);
        item_t p;
        logic  flag;
        case (shadow_sel[t])
            3'd0: flag = 1'b1;
            3'd1: flag = (r == '0);
            3'd2: flag = (r != '0);
            3'd3: flag = !r[`WORD_WIDTH-1];
            3'd4: flag = r[`WORD_WIDTH-1];
            3'd7: flag = !r[0];
            default: flag = 1'b0;   // Reserved
        endcase
        p.valid   = 1'b1;
        p.thread  = t;
        p.taken   = shadow_enable[t] && (shadow_origin[t] == pc) && flag;
        p.next_pc = p.taken ? shadow_dest[t] : pc_t'(pc + 1);
        return p;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("FAIL %0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
        end
    endtask

    task automatic give_up(input string what);
        $display("Timed out at %0t waiting for %s", $time, what);
        $display("Test failed");
        $finish;
    endtask

    task automatic axi_write(input axi_addr_t addr, input axi_data_t data,
                             input logic [3:0] strb, input int hold);
        int        waited;
        axi_data_t merged;
        @(posedge clock);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
        end while (!(awready && wready) && waited < TIMEOUT);
        if (!(awready && wready)) begin
            give_up("write accept");
        end else begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            merged = expected_word(addr[6:4], addr[3:2]);
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) merged[8*i +: 8] = data[8*i +: 8];
            end
            case (addr[3:2])    // Shadow changes on the accept edge, as the DUT does
                2'd0: shadow_origin[addr[6:4]] <= merged[`PC_WIDTH-1:0];
                2'd1: shadow_dest[addr[6:4]] <= merged[`PC_WIDTH-1:0];
                2'd2: begin
                    shadow_sel[addr[6:4]]    <= merged[2:0];
                    shadow_enable[addr[6:4]] <= merged[8];
                end
                default: ;
            endcase
            waited = 0;
            do begin
                @(posedge clock);
                waited++;
            end while (!bvalid && waited < TIMEOUT);
            if (!bvalid) begin
                give_up("bvalid");
            end else begin
                repeat (hold) begin
                    @(posedge clock);
                    check_value("bvalid", 32'd1, 32'(bvalid));
                end
                bready <= 1'b1;
                @(posedge clock);
                check_value("bresp", 32'd0, 32'(bresp));
                bready <= 1'b0;
            end
        end
    endtask

    task automatic read_compare(input axi_addr_t addr, input int hold);
        int        waited;
        axi_data_t held;
        @(posedge clock);
        araddr  <= addr;
        arvalid <= 1'b1;
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
        end while (!arready && waited < TIMEOUT);
        if (!arready) begin
            give_up("arready");
        end else begin
            arvalid <= 1'b0;
            waited = 0;
            do begin
                @(posedge clock);
                waited++;
            end while (!rvalid && waited < TIMEOUT);
            if (!rvalid) begin
                give_up("rvalid");
            end else begin
                held = rdata;
                check_value("rdata", expected_word(addr[6:4], addr[3:2]), rdata);
                repeat (hold) begin
                    @(posedge clock);
                    check_value("rvalid", 32'd1, 32'(rvalid));
                    check_value("rdata", held, rdata);
                end
                rready <= 1'b1;
                @(posedge clock);
                check_value("rresp", 32'd0, 32'(rresp));
                rready <= 1'b0;
            end
        end
    endtask

    task automatic program_entry(input thread_t t, input pc_t origin, input pc_t dest,
                                 input cond_sel_t sel, input logic enable);
        axi_addr_t base;
        base = {t, 4'h0};
        axi_write(base, 32'(origin), 4'hF, 0);
        axi_write(base | 7'h4, 32'(dest), 4'hF, 0);
        axi_write(base | 7'h8, {23'd0, enable, 5'd0, sel}, 4'hF, 0);
    endtask

    task automatic send_item(input thread_t t, input pc_t pc, input word_t r);
        @(posedge clock);
        in_valid  <= 1'b1;
        in_thread <= t;
        in_pc     <= pc;
        r_prev    <= r;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            in_valid <= 1'b0;
        end
    endtask

    // One item per rising edge, expected result leaves two edges later
    always @(posedge clock or negedge arst_n) begin
        item_t item;
        if (!arst_n) begin
            sent.delete();
            expected_out = '0;
        end else begin
            item       = predict(in_thread, in_pc, r_prev);
            item.valid = in_valid;
            sent.push_back(item);
            if (sent.size() > 1) expected_out = sent.pop_front();
        end
    end

    always @(negedge clock) begin
        if (arst_n === 1'b1) begin
            check_value("out_valid", 32'(expected_out.valid), 32'(out_valid));
            if (expected_out.valid) begin
                check_value("out_thread", 32'(expected_out.thread), 32'(out_thread));
                check_value("taken", 32'(expected_out.taken), 32'(taken));
                check_value("next_pc", 32'(expected_out.next_pc), 32'(next_pc));
            end
        end
    end

    initial begin
        thread_t rt;
        pc_t     rpc;
        word_t   rr;
        seed      = 93;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_thread = '0;
        in_pc     = '0;
        r_prev    = '0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        repeat (4) @(posedge clock);
        arst_n <= 1'b1;

        // Register map after reset, then full, partial and random writes
        for (int a = 0; a < 128; a += 4) read_compare(axi_addr_t'(a), 0);
        axi_write(7'h10, 32'hFFFF_F3A5, 4'hF, 0);
        axi_write(7'h14, 32'h0000_01FF, 4'hF, 0);
        axi_write(7'h18, 32'hFFFF_FF05, 4'hF, 0);
        axi_write(7'h1C, 32'hFFFF_FFFF, 4'hF, 0);
        axi_write(7'h20, 32'hFFFF_FFFF, 4'b0001, 0);    // Low byte of origin only
        axi_write(7'h20, 32'h0000_0200, 4'b0010, 0);
        axi_write(7'h28, 32'h0000_0100, 4'b0010, 0);    // Enable without select
        repeat (10) begin
            axi_write(axi_addr_t'($random(seed)) & 7'h7C, $random(seed), 4'($random(seed)), 0);
        end
        for (int a = 0; a < 128; a += 4) read_compare(axi_addr_t'(a), 0);

        // Every condition select against four result classes
        for (int sel = 0; sel < 8; sel++) begin
            program_entry(3'd4, 10'h120, 10'h2C0, cond_sel_t'(sel), 1'b1);
            foreach (results[k]) send_item(3'd4, 10'h120, results[k]);
            idle(3);
        end

        // Disabled entry and origin mismatch, PC wraps
        program_entry(3'd6, 10'h3FF, 10'h010, 3'd0, 1'b0);
        send_item(3'd6, 10'h3FF, 36'h0);
        send_item(3'd4, 10'h3FF, 36'h0);
        send_item(3'd4, 10'h121, 36'h0);
        idle(3);
        program_entry(3'd6, 10'h3FF, 10'h010, 3'd5, 1'b1);
        send_item(3'd6, 10'h3FF, 36'h5);
        send_item(3'd6, 10'h3FE, 36'h5);
        idle(3);

        // Back to back random items
        for (int t = 0; t < `THREAD_COUNT; t++) begin
            program_entry(thread_t'(t), pc_t'($random(seed)), pc_t'($random(seed)),
                          cond_sel_t'($random(seed)), 1'($random(seed)));
        end
        repeat (200) begin
            rt  = thread_t'($random(seed));
            rpc = ($random(seed) & 1) ? shadow_origin[rt] : pc_t'($random(seed));
            rr  = ($random(seed) % 4 == 0) ? '0 : word_t'({$random(seed), $random(seed)});
            send_item(rt, rpc, rr);
        end
        idle(3);

        // Slow response acceptance
        axi_write(7'h64, 32'h0000_0155, 4'hF, 5);
        read_compare(7'h64, 5);
        read_compare(7'h18, 6);

        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 branch_unit_inst.branch_unit_props_inst.failures);
        if (errors == 0 && branch_unit_inst.branch_unit_props_inst.failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
src/branch_pkg.sv
src/branch_flags.sv
src/branch_entry_regs.sv
src/branch_detector.sv
src/branch_unit.sv
tb/branch_unit_props.sv
tb/branch_unit_tb.sv
